/* compile.f */
hw/cache_pkg.sv
hw/credit_counter.sv
hw/request_fifo.sv
hw/bank_ctrl_fsm.sv
hw/cache_bank.sv
hw/packet_arbiter.sv
hw/unified_cache.sv
tests/unified_cache_sva.sv
tests/tb_unified_cache.sv

/* hw/bank_ctrl_fsm.sv */
module bank_ctrl_fsm
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   is_write,
    input  logic                   hit,
    input  logic                   grant,
    input  logic                   fill_valid,
    input  logic                   ret_grant,
    output cache_pkg::bank_state_t state,
    output logic                   req_valid,
    output logic                   ret_valid,
    output logic                   fill_write,
    output logic                   store_write
);
    import cache_pkg::*;

    bank_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= BANK_IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            BANK_IDLE:
            begin
                if (start)
                begin
                    next_state = BANK_LOOKUP;
                end
            end
            BANK_LOOKUP:
            begin
                // stores always go out to memory, hit or not
                next_state = (hit && !is_write) ? BANK_RESPOND : BANK_MISS_REQ;
            end
            BANK_MISS_REQ:
            begin
                if (grant)
                begin
                    next_state = is_write ? BANK_RESPOND : BANK_FILL_WAIT;
                end
            end
            BANK_FILL_WAIT:
            begin
                if (fill_valid)
                begin
                    next_state = BANK_RESPOND;
                end
            end
            BANK_RESPOND:
            begin
                if (ret_grant)
                begin
                    next_state = BANK_IDLE;
                end
            end
            default:
            begin
                next_state = BANK_IDLE;
            end
        endcase
    end

    assign req_valid   = (state == BANK_MISS_REQ);
    assign ret_valid   = (state == BANK_RESPOND);
    assign fill_write  = (state == BANK_FILL_WAIT) && fill_valid;
    // write-through, no allocate on a store miss
    assign store_write = (state == BANK_MISS_REQ) && is_write && hit && grant;

endmodule

/* hw/cache_bank.sv */
module cache_bank
#(
    parameter int BANK_ID  = 0,
    parameter int NUM_PORT = 2,
    parameter int NUM_BANK = 2,
    parameter int NUM_SET  = 16
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_PORT-1:0]      head_valid,
    input  cache_pkg::cache_packet_t head_packets [NUM_PORT],
    output logic [NUM_PORT-1:0]      take,
    output logic                     mem_req_valid,
    output cache_pkg::cache_packet_t mem_req_packet,
    input  logic                     mem_grant,
    input  logic                     fill_valid,
    input  cache_pkg::cache_packet_t fill_packet,
    output logic                     ret_valid,
    output cache_pkg::cache_packet_t ret_packet,
    input  logic                     ret_grant
);
    import cache_pkg::*;

    localparam int BANK_BITS = $clog2(NUM_BANK);
    localparam int SET_BITS  = $clog2(NUM_SET);
    localparam int SET_LSB   = BANK_LSB + BANK_BITS;
    localparam int TAG_LSB   = SET_LSB + SET_BITS;
    localparam int TAG_BITS  = ADDR_BITS - TAG_LSB;

    typedef logic [SET_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    cache_packet_t      sel_packet;
    cache_packet_t      req;
    word_t              resp_data;
    set_idx_t           req_set;
    tag_t               req_tag;
    logic               start;
    logic               hit;
    logic               fill_match;
    logic               fill_write;
    logic               store_write;
    bank_state_t        state;
    logic [NUM_SET-1:0] line_valid;
    tag_t               tag_mem [NUM_SET];
    word_t              data_mem [NUM_SET];

    function automatic logic in_bank(addr_t addr);
        return ((addr >> BANK_LSB) % addr_t'(NUM_BANK)) == addr_t'(BANK_ID);
    endfunction

    // lowest port aimed at this bank wins
    always_comb
    begin
        take       = '0;
        sel_packet = head_packets[0];
        for (int p = NUM_PORT - 1; p >= 0; p--)
        begin
            if (head_valid[p] && in_bank(head_packets[p].addr))
            begin
                take       = '0;
                take[p]    = (state == BANK_IDLE);
                sel_packet = head_packets[p];
            end
        end
    end

    assign start      = |take;
    assign req_set    = set_idx_t'(req.addr >> SET_LSB);
    assign req_tag    = tag_t'(req.addr >> TAG_LSB);
    assign hit        = line_valid[req_set] && (tag_mem[req_set] == req_tag);
    // one outstanding read per bank, so bank bits are enough to claim a fill
    assign fill_match = fill_valid && in_bank(fill_packet.addr);

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            req       <= sel_packet;
            resp_data <= sel_packet.data;
        end
        else if (state == BANK_LOOKUP && !req.is_write)
        begin
            resp_data <= data_mem[req_set];
        end
        else if (fill_write)
        begin
            resp_data <= fill_packet.data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            line_valid <= '0;
        end
        else if (fill_write)
        begin
            line_valid[req_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_write || store_write)
        begin
            tag_mem[req_set]  <= req_tag;
            data_mem[req_set] <= fill_write ? fill_packet.data : req.data;
        end
    end

    bank_ctrl_fsm u_fsm
    (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .is_write    (req.is_write),
        .hit         (hit),
        .grant       (mem_grant),
        .fill_valid  (fill_match),
        .ret_grant   (ret_grant),
        .state       (state),
        .req_valid   (mem_req_valid),
        .ret_valid   (ret_valid),
        .fill_write  (fill_write),
        .store_write (store_write)
    );

    assign mem_req_packet = req;

    always_comb
    begin
        ret_packet      = req;
        ret_packet.data = resp_data;
    end

endmodule

/* hw/cache_pkg.sv */
package cache_pkg;

    localparam int ADDR_BITS    = 16;
    localparam int WORD_BITS    = 32;
    localparam int PORT_ID_BITS = 1;

    // bank select sits at the bottom of the word address
    localparam int BANK_LSB = 0;

    typedef logic [ADDR_BITS-1:0]    addr_t;
    typedef logic [WORD_BITS-1:0]    word_t;
    typedef logic [PORT_ID_BITS-1:0] port_id_t;

    // same layout on every link, in and out
    typedef struct packed {
        addr_t    addr;
        word_t    data;
        logic     is_write;
        port_id_t port_id;
    } cache_packet_t;

    typedef enum logic [2:0] {
        BANK_IDLE,
        BANK_LOOKUP,
        BANK_MISS_REQ,
        BANK_FILL_WAIT,
        BANK_RESPOND
    } bank_state_t;

endpackage

/* hw/credit_counter.sv */
module credit_counter
#(
    parameter int CREDITS = 2
)
(
    input  logic clk,
    input  logic reset,
    input  logic consume,
    input  logic release_credit,
    output logic available
);

    localparam int CNT_BITS = $clog2(CREDITS + 1);

    typedef logic [CNT_BITS-1:0] count_t;

    count_t count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= count_t'(CREDITS);
        end
        else if (consume && !release_credit)
        begin
            count <= count - count_t'(1);
        end
        else if (release_credit && !consume)
        begin
            count <= count + count_t'(1);
        end
    end

    assign available = (count != '0);

endmodule

/* hw/packet_arbiter.sv */
module packet_arbiter
#(
    parameter int NUM_REQ = 2,
    parameter int CREDITS = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_REQ-1:0]       req_valid,
    input  cache_pkg::cache_packet_t req_packets [NUM_REQ],
    input  logic                     credit_in,
    output logic [NUM_REQ-1:0]       grant,
    output logic                     out_valid,
    output cache_pkg::cache_packet_t out_packet
);

    logic available;

    credit_counter
    #(
        .CREDITS (CREDITS)
    )
    u_credits
    (
        .clk            (clk),
        .reset          (reset),
        .consume        (out_valid),
        .release_credit (credit_in),
        .available      (available)
    );

    // index 0 has the highest priority
    always_comb
    begin
        grant      = '0;
        out_packet = req_packets[0];
        for (int i = NUM_REQ - 1; i >= 0; i--)
        begin
            if (req_valid[i])
            begin
                grant      = '0;
                grant[i]   = available;
                out_packet = req_packets[i];
            end
        end
    end

    assign out_valid = |grant;

endmodule

/* hw/request_fifo.sv */
module request_fifo
#(
    parameter int DEPTH = 4
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  cache_pkg::cache_packet_t in_packet,
    input  logic                     take,
    output logic                     head_valid,
    output cache_pkg::cache_packet_t head_packet,
    output logic                     credit
);
    import cache_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] count_t;

    cache_packet_t entries [DEPTH];
    ptr_t          wr_ptr;
    ptr_t          rd_ptr;
    count_t        count;

    // wrap for depths that are not a power of two
    function automatic ptr_t next_ptr(ptr_t ptr);
        return (ptr == ptr_t'(DEPTH - 1)) ? '0 : ptr + ptr_t'(1);
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            // slot freed now, credit goes back next cycle
            credit <= take;
            if (in_valid)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (in_valid && !take)
            begin
                count <= count + count_t'(1);
            end
            else if (take && !in_valid)
            begin
                count <= count - count_t'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)
        begin
            entries[wr_ptr] <= in_packet;
        end
    end

    assign head_valid  = (count != '0);
    assign head_packet = entries[rd_ptr];

endmodule

/* hw/unified_cache.sv */
module unified_cache
#(
    parameter int NUM_PORT       = 2,
    parameter int NUM_BANK       = 2,
    parameter int NUM_SET        = 16,
    parameter int QUEUE_DEPTH    = 4,
    parameter int MEM_CREDITS    = 2,
    parameter int RETURN_CREDITS = 2
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_PORT-1:0]      in_valid,
    input  cache_pkg::cache_packet_t in_packet [NUM_PORT],
    output logic [NUM_PORT-1:0]      in_credit,
    output logic [NUM_PORT-1:0]      ret_valid,
    output cache_pkg::cache_packet_t ret_packet [NUM_PORT],
    input  logic [NUM_PORT-1:0]      ret_credit,
    output logic                     mem_req_valid,
    output cache_pkg::cache_packet_t mem_req_packet,
    input  logic                     mem_req_credit,
    input  logic                     mem_rsp_valid,
    input  cache_pkg::cache_packet_t mem_rsp_packet
);
    import cache_pkg::*;

    logic [NUM_PORT-1:0] head_valid;
    cache_packet_t       head_packet [NUM_PORT];
    logic [NUM_PORT-1:0] queue_take;
    logic [NUM_PORT-1:0] bank_take [NUM_BANK];
    logic [NUM_BANK-1:0] bank_mem_valid;
    cache_packet_t       bank_mem_packet [NUM_BANK];
    logic [NUM_BANK-1:0] bank_mem_grant;
    logic [NUM_BANK-1:0] bank_ret_valid;
    cache_packet_t       bank_ret_packet [NUM_BANK];
    logic [NUM_BANK-1:0] bank_ret_grant;
    logic [NUM_BANK-1:0] port_ret_grant [NUM_PORT];

    for (genvar p = 0; p < NUM_PORT; p++)
    begin : g_queue
        request_fifo
        #(
            .DEPTH (QUEUE_DEPTH)
        )
        u_queue
        (
            .clk         (clk),
            .reset       (reset),
            .in_valid    (in_valid[p]),
            .in_packet   (in_packet[p]),
            .take        (queue_take[p]),
            .head_valid  (head_valid[p]),
            .head_packet (head_packet[p]),
            .credit      (in_credit[p])
        );
    end

    // a head maps to one bank only, so the takes never collide
    always_comb
    begin
        queue_take = '0;
        for (int b = 0; b < NUM_BANK; b++)
        begin
            queue_take |= bank_take[b];
        end
    end

    always_comb
    begin
        bank_ret_grant = '0;
        for (int p = 0; p < NUM_PORT; p++)
        begin
            bank_ret_grant |= port_ret_grant[p];
        end
    end

    for (genvar b = 0; b < NUM_BANK; b++)
    begin : g_bank
        cache_bank
        #(
            .BANK_ID  (b),
            .NUM_PORT (NUM_PORT),
            .NUM_BANK (NUM_BANK),
            .NUM_SET  (NUM_SET)
        )
        u_bank
        (
            .clk            (clk),
            .reset          (reset),
            .head_valid     (head_valid),
            .head_packets   (head_packet),
            .take           (bank_take[b]),
            .mem_req_valid  (bank_mem_valid[b]),
            .mem_req_packet (bank_mem_packet[b]),
            .mem_grant      (bank_mem_grant[b]),
            .fill_valid     (mem_rsp_valid),
            .fill_packet    (mem_rsp_packet),
            .ret_valid      (bank_ret_valid[b]),
            .ret_packet     (bank_ret_packet[b]),
            .ret_grant      (bank_ret_grant[b])
        );
    end

    packet_arbiter
    #(
        .NUM_REQ (NUM_BANK),
        .CREDITS (MEM_CREDITS)
    )
    u_mem_arb
    (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (bank_mem_valid),
        .req_packets (bank_mem_packet),
        .credit_in   (mem_req_credit),
        .grant       (bank_mem_grant),
        .out_valid   (mem_req_valid),
        .out_packet  (mem_req_packet)
    );

    for (genvar p = 0; p < NUM_PORT; p++)
    begin : g_ret
        logic [NUM_BANK-1:0] ret_req;

        // only banks answering this port compete here
        always_comb
        begin
            for (int b = 0; b < NUM_BANK; b++)
            begin
                ret_req[b] = bank_ret_valid[b] && (bank_ret_packet[b].port_id == port_id_t'(p));
            end
        end

        packet_arbiter
        #(
            .NUM_REQ (NUM_BANK),
            .CREDITS (RETURN_CREDITS)
        )
        u_ret_arb
        (
            .clk         (clk),
            .reset       (reset),
            .req_valid   (ret_req),
            .req_packets (bank_ret_packet),
            .credit_in   (ret_credit[p]),
            .grant       (port_ret_grant[p]),
            .out_valid   (ret_valid[p]),
            .out_packet  (ret_packet[p])
        );
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns -f compile.f \
    --top-module tb_unified_cache -Mdir obj_dir -o sim_unified_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_unified_cache > sim.log 2>&1
status=$?
cat sim.log
if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

/* tests/tb_unified_cache.sv */
module tb_unified_cache;
    timeunit 1ns;
    timeprecision 1ns;
    import cache_pkg::*;

    localparam int    NUM_PORT       = 2;
    localparam int    NUM_BANK       = 2;
    localparam int    NUM_SET        = 16;
    localparam int    QUEUE_DEPTH    = 4;
    localparam int    MEM_CREDITS    = 2;
    localparam int    RETURN_CREDITS = 2;
    localparam int    NUM_REQUESTS   = 88;
    localparam int    TIMEOUT_CYCLES = 40 * NUM_REQUESTS;
    localparam addr_t STORE_BASE     = 16'h8000;

    logic                clk = 1'b0;
    logic                reset = 1'b1;
    logic [NUM_PORT-1:0] in_valid;
    cache_packet_t       in_packet [NUM_PORT];
    logic [NUM_PORT-1:0] in_credit;
    logic [NUM_PORT-1:0] ret_valid;
    cache_packet_t       ret_packet [NUM_PORT];
    logic [NUM_PORT-1:0] ret_credit;
    logic                mem_req_valid;
    cache_packet_t       mem_req_packet;
    logic                mem_req_credit;
    logic                mem_rsp_valid;
    cache_packet_t       mem_rsp_packet;

    word_t         mem_words [65536];
    word_t         ref_words [65536];
    cache_packet_t pend_q [NUM_PORT][$];
    cache_packet_t open_q [NUM_PORT][$];
    cache_packet_t mem_fifo [$];
    logic [31:0]   rng_state = 32'd82;
    logic          running = 1'b0;
    logic          first_cycle = 1'b1;
    int            in_held [NUM_PORT];
    int            in_pulses [NUM_PORT];
    int            ret_held [NUM_PORT];
    int            ret_owed [NUM_PORT];
    int            issued [NUM_PORT];
    int            pushed_total;
    int            returned_total;
    int            mem_held;
    int            mem_req_count;
    int            mem_store_count;
    int            cycle_count;

    unified_cache
    #(
        .NUM_PORT       (NUM_PORT),
        .NUM_BANK       (NUM_BANK),
        .NUM_SET        (NUM_SET),
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .MEM_CREDITS    (MEM_CREDITS),
        .RETURN_CREDITS (RETURN_CREDITS)
    )
    dut0
    (
        .clk            (clk),
        .reset          (reset),
        .in_valid       (in_valid),
        .in_packet      (in_packet),
        .in_credit      (in_credit),
        .ret_valid      (ret_valid),
        .ret_packet     (ret_packet),
        .ret_credit     (ret_credit),
        .mem_req_valid  (mem_req_valid),
        .mem_req_packet (mem_req_packet),
        .mem_req_credit (mem_req_credit),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_packet (mem_rsp_packet)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // backing store contents before any write
    function automatic word_t fill_pattern(input addr_t a);
        return {a ^ 16'hc35a, a * 16'd7 + 16'h0b1d};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TB FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("[FAIL] %0t ns: %s", $time, msg));
    endtask

    // a return must answer a request still open on its port
    task automatic retire_request(input int p);
        int idx;
        idx = -1;
        for (int i = 0; i < open_q[p].size(); i++)
        begin
            if (idx < 0 && open_q[p][i].addr == ret_packet[p].addr &&
                open_q[p][i].is_write == ret_packet[p].is_write)
            begin
                idx = i;
            end
        end
        assert (idx >= 0)
            else value_error($sformatf("port %0d return for %h matches no open request", p,
                                       ret_packet[p].addr));
        open_q[p].delete(idx);
    endtask

    task automatic push_request(input int port, input addr_t addr, input word_t data,
                                input logic is_write);
        cache_packet_t pkt;
        pkt.addr     = addr;
        pkt.data     = data;
        pkt.is_write = is_write;
        pkt.port_id  = port_id_t'(port);
        if (is_write)
        begin
            ref_words[addr] = data;
        end
        pend_q[port].push_back(pkt);
        pushed_total++;
    endtask

    task automatic wait_returns();
        while (returned_total != pushed_total)
        begin
            @(posedge clk);
        end
    endtask

    // in-order memory, answers one cycle or more after arrival
    task automatic model_memory();
        cache_packet_t req;
        cache_packet_t rsp;
        mem_rsp_valid  = 1'b0;
        mem_req_credit = 1'b0;
        if (mem_req_valid)
        begin
            assert (mem_held > 0) else value_error("mem_req_valid with no memory credit");
            mem_held--;
            mem_req_count++;
        end
        if (mem_fifo.size() > 0 && (rand_word() & 32'h1) != 0)
        begin
            req = mem_fifo.pop_front();
            if (req.is_write)
            begin
                mem_words[req.addr] = req.data;
            end
            else
            begin
                rsp            = req;
                rsp.data       = mem_words[req.addr];
                mem_rsp_packet = rsp;
                mem_rsp_valid  = 1'b1;
            end
            mem_req_credit = 1'b1;
            mem_held++;
        end
        if (mem_req_valid)
        begin
            if (mem_req_packet.is_write)
            begin
                mem_store_count++;
                assert (mem_req_packet.data == ref_words[mem_req_packet.addr])
                    else value_error($sformatf("store to %h carries %h", mem_req_packet.addr,
                                               mem_req_packet.data));
            end
            mem_fifo.push_back(mem_req_packet);
        end
    endtask

    task automatic model_requesters();
        for (int p = 0; p < NUM_PORT; p++)
        begin
            if (in_credit[p])
            begin
                in_held[p]++;
                in_pulses[p]++;
            end
            if (ret_valid[p])
            begin
                assert (ret_held[p] > 0)
                    else value_error($sformatf("port %0d return with no credit", p));
                assert (ret_packet[p].port_id == port_id_t'(p))
                    else value_error($sformatf("port %0d return tagged for port %0d", p,
                                               ret_packet[p].port_id));
                retire_request(p);
                assert (ret_packet[p].data == ref_words[ret_packet[p].addr])
                    else value_error($sformatf("port %0d addr %h data %h, expected %h", p,
                                               ret_packet[p].addr, ret_packet[p].data,
                                               ref_words[ret_packet[p].addr]));
                ret_held[p]--;
                ret_owed[p]++;
                returned_total++;
            end
            ret_credit[p] = 1'b0;
            if (ret_owed[p] > 0 && (rand_word() & 32'h1) != 0)
            begin
                ret_credit[p] = 1'b1;
                ret_owed[p]--;
                ret_held[p]++;
            end
            in_valid[p] = 1'b0;
            if (in_held[p] > 0 && pend_q[p].size() > 0 && (rand_word() & 32'h3) != 0)
            begin
                in_packet[p] = pend_q[p].pop_front();
                in_valid[p]  = 1'b1;
                open_q[p].push_back(in_packet[p]);
                in_held[p]--;
                issued[p]++;
            end
        end
    endtask

    always @(negedge clk)
    begin
        if (running)
        begin
            if (first_cycle)
            begin
                assert (in_credit == '0 && ret_valid == '0 && !mem_req_valid)
                    else value_error("outputs active in the first cycle after reset");
                first_cycle = 1'b0;
            end
            model_memory();
            model_requesters();
        end
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            abort_run($sformatf("timeout: requests still open after %0d cycles",
                                TIMEOUT_CYCLES));
        end
    end

    initial
    begin
        addr_t addr;
        int    snapshot;
        int    stores;
        for (int i = 0; i < 65536; i++)
        begin
            mem_words[i] = fill_pattern(addr_t'(i));
            ref_words[i] = mem_words[i];
        end
        for (int p = 0; p < NUM_PORT; p++)
        begin
            in_held[p]   = QUEUE_DEPTH;
            ret_held[p]  = RETURN_CREDITS;
            in_pulses[p] = 0;
            ret_owed[p]  = 0;
            issued[p]    = 0;
            in_packet[p] = '0;
        end
        pushed_total    = 0;
        returned_total  = 0;
        mem_held        = MEM_CREDITS;
        mem_req_count   = 0;
        mem_store_count = 0;
        cycle_count     = 0;
        stores          = 0;
        in_valid        = '0;
        ret_credit      = '0;
        mem_req_credit  = 1'b0;
        mem_rsp_valid   = 1'b0;
        mem_rsp_packet  = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        running = 1'b1;

        // second read of a line must stay inside the cache
        for (int k = 0; k < 4; k++)
        begin
            addr = addr_t'(rand_word() % 128);
            push_request(k % 2, addr, '0, 1'b0);
            wait_returns();
            snapshot = mem_req_count;
            push_request(k % 2, addr, '0, 1'b0);
            wait_returns();
            assert (mem_req_count == snapshot)
                else value_error($sformatf("repeat read of %h went to memory", addr));
        end

        for (int k = 0; k < 24; k++)
        begin
            push_request(0, addr_t'(rand_word() % 128), '0, 1'b0);
            push_request(1, addr_t'(rand_word() % 128), '0, 1'b0);
        end
        wait_returns();

        // first round misses, second round hits the lines read back
        for (int r = 0; r < 2; r++)
        begin
            for (int k = 0; k < 8; k++)
            begin
                push_request(1, STORE_BASE + addr_t'(k), rand_word(), 1'b1);
                stores++;
            end
            wait_returns();
            assert (mem_store_count == stores)
                else value_error($sformatf("%0d stores on memory link, expected %0d",
                                           mem_store_count, stores));
            for (int k = 0; k < 8; k++)
            begin
                push_request(k % 2, STORE_BASE + addr_t'(k), '0, 1'b0);
            end
            wait_returns();
        end

        repeat (2) @(posedge clk);
        for (int p = 0; p < NUM_PORT; p++)
        begin
            assert (in_pulses[p] == issued[p])
                else value_error($sformatf("port %0d gave %0d credits for %0d packets", p,
                                           in_pulses[p], issued[p]));
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tests/unified_cache_sva.sv */
module unified_cache_sva
#(
    parameter int NUM_PORT = 2,
    parameter int NUM_BANK = 2
)
(
    input logic                     clk,
    input logic                     reset,
    input logic [NUM_PORT-1:0]      in_credit,
    input logic [NUM_PORT-1:0]      ret_valid,
    input logic                     mem_req_valid,
    input logic [NUM_BANK-1:0]      bank_mem_valid,
    input cache_pkg::cache_packet_t bank_mem_packet [NUM_BANK],
    input logic [NUM_BANK-1:0]      bank_mem_grant,
    input logic [NUM_BANK-1:0]      bank_ret_valid,
    input cache_pkg::cache_packet_t bank_ret_packet [NUM_BANK],
    input logic [NUM_BANK-1:0]      bank_ret_grant
);
    timeunit 1ns;
    timeprecision 1ns;

    // nothing leaves the cache right after reset
    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> (in_credit == '0 && ret_valid == '0 && !mem_req_valid))
        else $error("cache output active in the first cycle after reset");

    for (genvar b = 0; b < NUM_BANK; b++)
    begin : g_hold
        // a waiting bank keeps request and packet until granted
        mem_req_held: assert property (@(posedge clk) disable iff (reset)
            bank_mem_valid[b] && !bank_mem_grant[b]
                |=> bank_mem_valid[b] && $stable(bank_mem_packet[b]))
            else $error("bank changed its memory request before a grant");

        ret_req_held: assert property (@(posedge clk) disable iff (reset)
            bank_ret_valid[b] && !bank_ret_grant[b]
                |=> bank_ret_valid[b] && $stable(bank_ret_packet[b]))
            else $error("bank changed its return packet before a grant");
    end

endmodule

bind unified_cache unified_cache_sva
#(
    .NUM_PORT (NUM_PORT),
    .NUM_BANK (NUM_BANK)
)
u_sva
(
    .clk             (clk),
    .reset           (reset),
    .in_credit       (in_credit),
    .ret_valid       (ret_valid),
    .mem_req_valid   (mem_req_valid),
    .bank_mem_valid  (bank_mem_valid),
    .bank_mem_packet (bank_mem_packet),
    .bank_mem_grant  (bank_mem_grant),
    .bank_ret_valid  (bank_ret_valid),
    .bank_ret_packet (bank_ret_packet),
    .bank_ret_grant  (bank_ret_grant)
);
